// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cpuTb
FILELIST := build.f
OBJDIR   := obj_dir
PASS     := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS)'

clean:
	rm -rf $(OBJDIR)

// File: build.f
+incdir+include
hdl/cpuIsaPkg.sv
hdl/cpuBusPkg.sv
hdl/controlUnit.sv
hdl/registerBank.sv
hdl/memPort.sv
hdl/cpuTop.sv
test/cpuChecker.sv
test/cpuTb.sv

// File: hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic                 clk,
	input  logic                 rstN,
	input  cpuIsaPkg::opcode_e   opcode,
	input  logic                 zero,
	input  logic                 ack,
	output cpuBusPkg::ctrlWord_t ctrl,
	output logic                 halted
);

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		OPREAD,
		OPLOAD,
		DATAREAD,
		DATALOAD,
		STORE,
		EXEC,
		HALTED
	} state_e;

	state_e state;
	state_e stateNext;

	// ******************************
	// control word per state
	// ******************************

	function automatic cpuBusPkg::ctrlWord_t ctrlFor(state_e s, cpuIsaPkg::opcode_e op);
		cpuBusPkg::ctrlWord_t c;
		c = cpuBusPkg::CTRL_IDLE;
		case (s)
			FETCH: begin
				c.memRead = 1'b1;	// at PC.
			end
			DECODE: begin
				c.busSrc                     = cpuBusPkg::BUS_MEM;
				c.writeEn[cpuIsaPkg::REG_IR] = 1'b1;
				c.incEn[cpuIsaPkg::REG_PC]   = 1'b1;
			end
			OPREAD: begin
				c.memRead = 1'b1;	// immediate byte sits at PC.
			end
			OPLOAD: begin
				c.busSrc = cpuBusPkg::BUS_MEM;
				if (op == cpuIsaPkg::LDADDR) begin
					c.writeEn[cpuIsaPkg::REG_ADDR] = 1'b1;
					c.incEn[cpuIsaPkg::REG_PC]     = 1'b1;
				end else begin
					c.writeEn[cpuIsaPkg::REG_PC] = 1'b1;	// taken jump.
				end
			end
			DATAREAD: begin
				c.memRead = 1'b1;
				c.addrSrc = cpuBusPkg::ASRC_ADDR;
			end
			DATALOAD: begin
				c.busSrc                     = cpuBusPkg::BUS_MEM;
				c.writeEn[cpuIsaPkg::REG_AC] = 1'b1;
			end
			STORE: begin
				c.memWrite = 1'b1;
				c.addrSrc  = cpuBusPkg::ASRC_STP;
			end
			EXEC: begin
				case (op)
					cpuIsaPkg::ADD: begin
						c.busSrc                     = cpuBusPkg::BUS_SUM;
						c.writeEn[cpuIsaPkg::REG_AC] = 1'b1;
					end
					cpuIsaPkg::INCAC:  c.incEn[cpuIsaPkg::REG_AC] = 1'b1;
					cpuIsaPkg::RSTAC:  c.rstEn[cpuIsaPkg::REG_AC] = 1'b1;
					cpuIsaPkg::MADDR:  c.writeEn[cpuIsaPkg::REG_ADDR] = 1'b1;
					cpuIsaPkg::MSTP:   c.writeEn[cpuIsaPkg::REG_STP] = 1'b1;
					cpuIsaPkg::INCSTP: c.incEn[cpuIsaPkg::REG_STP] = 1'b1;
					cpuIsaPkg::JMPZ:   c.incEn[cpuIsaPkg::REG_PC] = 1'b1;	// skip operand.
					default: ;
				endcase
			end
			default: ;
		endcase
		return c;
	endfunction

	// ******************************
	// sequencing
	// ******************************

	always_comb begin
		stateNext = state;
		case (state)
			FETCH:    if (ack) stateNext = DECODE;
			OPREAD:   if (ack) stateNext = OPLOAD;
			DATAREAD: if (ack) stateNext = DATALOAD;
			STORE:    if (ack) stateNext = FETCH;
			DECODE: begin
				case (opcode)
					cpuIsaPkg::HALT:   stateNext = HALTED;
					cpuIsaPkg::LDADDR: stateNext = OPREAD;
					cpuIsaPkg::JMP:    stateNext = OPREAD;
					cpuIsaPkg::JMPZ:   stateNext = zero ? OPREAD : EXEC;
					cpuIsaPkg::LDAC:   stateNext = DATAREAD;
					cpuIsaPkg::STSP:   stateNext = STORE;
					default:           stateNext = EXEC;
				endcase
			end
			HALTED:   stateNext = HALTED;
			default:  stateNext = FETCH;	// OPLOAD, DATALOAD, EXEC.
		endcase
	end

	// ctrl is registered from the next state, so it lines up with state.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= FETCH;
			ctrl  <= ctrlFor(FETCH, cpuIsaPkg::HALT);
		end else begin
			state <= stateNext;
			ctrl  <= ctrlFor(stateNext, opcode);
		end
	end

	assign halted = (state == HALTED);

	// an ack only comes back while this state asks for an access.
	assert property (@(posedge clk) disable iff (!rstN)
		ack |-> ctrl.memRead || ctrl.memWrite);

	assert property (@(posedge clk) disable iff (!rstN)
		((ctrl.writeEn & ctrl.incEn) | (ctrl.writeEn & ctrl.rstEn) |
		 (ctrl.incEn & ctrl.rstEn)) == '0);

endmodule

// File: hdl/cpuBusPkg.sv
package cpuBusPkg;

	// ******************************
	// datapath selects
	// ******************************

	// what drives the internal bus.
	typedef enum logic [1:0] {
		BUS_AC  = 2'd0,
		BUS_MEM = 2'd1,	// captured read data.
		BUS_SUM = 2'd2	// AC + ADDR.
	} busSrc_e;

	// where the memory address comes from.
	typedef enum logic [1:0] {
		ASRC_PC   = 2'd0,
		ASRC_ADDR = 2'd1,
		ASRC_STP  = 2'd2
	} addrSrc_e;

	// ******************************
	// control word and memory request
	// ******************************

	typedef struct packed {
		busSrc_e             busSrc;
		addrSrc_e            addrSrc;
		cpuIsaPkg::regMask_t writeEn;
		cpuIsaPkg::regMask_t incEn;
		cpuIsaPkg::regMask_t rstEn;
		logic                memRead;
		logic                memWrite;
	} ctrlWord_t;

	localparam ctrlWord_t CTRL_IDLE = '{
		busSrc: BUS_AC, addrSrc: ASRC_PC, writeEn: '0, incEn: '0, rstEn: '0,
		memRead: 1'b0, memWrite: 1'b0
	};

	typedef struct packed {
		logic             valid;
		logic             write;
		cpuIsaPkg::word_t addr;
		cpuIsaPkg::word_t wdata;
	} memReq_t;

endpackage

// File: hdl/cpuIsaPkg.sv
package cpuIsaPkg;

	// ******************************
	// data and address words
	// ******************************

	typedef logic [7:0] word_t;	// one byte, data or address.

	// ******************************
	// instruction set
	// ******************************

	// any encoding not listed falls through as a no-op.
	typedef enum logic [7:0] {
		HALT   = 8'h00,
		LDADDR = 8'h01,	// ADDR <- immediate.
		LDAC   = 8'h02,	// AC <- mem[ADDR].
		ADD    = 8'h03,
		INCAC  = 8'h04,
		RSTAC  = 8'h05,
		MADDR  = 8'h06,	// ADDR <- AC.
		MSTP   = 8'h07,	// STP <- AC.
		INCSTP = 8'h08,
		STSP   = 8'h09,	// mem[STP] <- AC.
		JMP    = 8'h0A,
		JMPZ   = 8'h0B
	} opcode_e;

	// ******************************
	// register select
	// ******************************

	localparam int REG_COUNT = 5;

	localparam int REG_PC   = 0;
	localparam int REG_IR   = 1;
	localparam int REG_ADDR = 2;
	localparam int REG_AC   = 3;
	localparam int REG_STP  = 4;

	typedef logic [REG_COUNT-1:0] regMask_t;	// one bit per register.

endpackage

// File: hdl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic               clk,
	input  logic               rstN,
	output cpuBusPkg::memReq_t memReq,
	input  logic               memAck,
	input  cpuIsaPkg::word_t   memRdata,
	output logic               halted
);

	cpuBusPkg::ctrlWord_t ctrl;
	cpuIsaPkg::opcode_e   opcode;
	logic                 zero;
	logic                 ack;
	cpuIsaPkg::word_t     pc;
	cpuIsaPkg::word_t     addr;
	cpuIsaPkg::word_t     ac;
	cpuIsaPkg::word_t     stp;
	cpuIsaPkg::word_t     memData;

	controlUnit uControl (
		.clk    (clk),
		.rstN   (rstN),
		.opcode (opcode),
		.zero   (zero),
		.ack    (ack),
		.ctrl   (ctrl),
		.halted (halted)
	);

	registerBank uRegs (
		.clk     (clk),
		.rstN    (rstN),
		.ctrl    (ctrl),
		.memData (memData),
		.opcode  (opcode),
		.zero    (zero),
		.pc      (pc),
		.addr    (addr),
		.ac      (ac),
		.stp     (stp)
	);

	memPort uMem (
		.clk      (clk),
		.rstN     (rstN),
		.ctrl     (ctrl),
		.pc       (pc),
		.addr     (addr),
		.stp      (stp),
		.ac       (ac),
		.memReq   (memReq),
		.memAck   (memAck),
		.memRdata (memRdata),
		.ack      (ack),
		.memData  (memData)
	);

endmodule

// File: hdl/memPort.sv
`timescale 1ns/1ps

module memPort (
	input  logic                 clk,
	input  logic                 rstN,
	input  cpuBusPkg::ctrlWord_t ctrl,
	input  cpuIsaPkg::word_t     pc,
	input  cpuIsaPkg::word_t     addr,
	input  cpuIsaPkg::word_t     stp,
	input  cpuIsaPkg::word_t     ac,
	output cpuBusPkg::memReq_t   memReq,
	input  logic                 memAck,
	input  cpuIsaPkg::word_t     memRdata,
	output logic                 ack,
	output cpuIsaPkg::word_t     memData
);

	logic             wantReq;
	logic             reqValid;
	logic             reqWrite;
	cpuIsaPkg::word_t addrSel;
	cpuIsaPkg::word_t reqAddr;
	cpuIsaPkg::word_t reqWdata;

	assign wantReq = ctrl.memRead || ctrl.memWrite;

	always_comb begin
		case (ctrl.addrSrc)
			cpuBusPkg::ASRC_ADDR: addrSel = addr;
			cpuBusPkg::ASRC_STP:  addrSel = stp;
			default:              addrSel = pc;
		endcase
	end

	assign ack = reqValid && memAck;	// accepted transfer.

	always_ff @(posedge clk) begin
		if (!rstN) begin
			reqValid <= 1'b0;
		end else if (ack) begin
			reqValid <= 1'b0;
		end else if (wantReq) begin
			reqValid <= 1'b1;
		end
	end

	// fields latch once, when the request goes out.
	always_ff @(posedge clk) begin
		if (wantReq && !reqValid) begin
			reqWrite <= ctrl.memWrite;
			reqAddr  <= addrSel;
			reqWdata <= ac;
		end
		if (ack && !reqWrite) begin
			memData <= memRdata;
		end
	end

	assign memReq = '{valid: reqValid, write: reqWrite, addr: reqAddr, wdata: reqWdata};

	// a waiting request still matches the address source and AC it was built from.
	assert property (@(posedge clk) disable iff (!rstN)
		reqValid |-> addrSel == reqAddr && (!reqWrite || reqWdata == ac));

endmodule

// File: hdl/registerBank.sv
`timescale 1ns/1ps

module registerBank (
	input  logic                 clk,
	input  logic                 rstN,
	input  cpuBusPkg::ctrlWord_t ctrl,
	input  cpuIsaPkg::word_t     memData,
	output cpuIsaPkg::opcode_e   opcode,
	output logic                 zero,
	output cpuIsaPkg::word_t     pc,
	output cpuIsaPkg::word_t     addr,
	output cpuIsaPkg::word_t     ac,
	output cpuIsaPkg::word_t     stp
);

	cpuIsaPkg::word_t regQ [cpuIsaPkg::REG_COUNT];	// indexed by REG_*.
	cpuIsaPkg::word_t busVal;
	cpuIsaPkg::word_t sum;
	cpuIsaPkg::word_t irVal;

	// ******************************
	// internal bus
	// ******************************

	assign sum = ac + addr;	// wraps at 256.

	always_comb begin
		case (ctrl.busSrc)
			cpuBusPkg::BUS_MEM: busVal = memData;
			cpuBusPkg::BUS_SUM: busVal = sum;
			default:            busVal = ac;
		endcase
	end

	// ******************************
	// registers
	// ******************************

	// reset wins over increment, increment over write.
	always_ff @(posedge clk) begin
		for (int i = 0; i < cpuIsaPkg::REG_COUNT; i++) begin
			if (!rstN || ctrl.rstEn[i]) begin
				regQ[i] <= '0;
			end else if (ctrl.incEn[i]) begin
				regQ[i] <= regQ[i] + 8'd1;
			end else if (ctrl.writeEn[i]) begin
				regQ[i] <= busVal;
			end
		end
	end

	assign pc   = regQ[cpuIsaPkg::REG_PC];
	assign addr = regQ[cpuIsaPkg::REG_ADDR];
	assign ac   = regQ[cpuIsaPkg::REG_AC];
	assign stp  = regQ[cpuIsaPkg::REG_STP];

	// while IR loads the new byte is passed through, so decode can branch on it
	// in the same cycle.
	assign irVal = ctrl.writeEn[cpuIsaPkg::REG_IR] ? busVal : regQ[cpuIsaPkg::REG_IR];

	assign opcode = cpuIsaPkg::opcode_e'(irVal);
	assign zero   = (ac == '0);

endmodule

// File: test/cpuChecker.sv
`timescale 1ns/1ps

module cpuChecker (
	input logic               clk,
	input logic               rstN,
	input cpuBusPkg::memReq_t memReq,
	input logic               memAck,
	input logic               halted
);

	logic [16:0]        expTxn [$];
	int                 idx;
	int                 errors;
	string              testName;
	logic               prevValid;
	logic               prevAcc;
	logic               inReset;
	cpuBusPkg::memReq_t prevReq;

	task automatic arm(input string name);
		testName = name;
		errors = 0;
	endtask

	task automatic rewind();
		expTxn.delete();
		idx = 0;
	endtask

	task automatic addExpected(input logic [16:0] t);
		expTxn.push_back(t);
	endtask

	task automatic reportError(input string what);
		$display("ERROR %s: %s", testName, what);
		errors++;
	endtask

	function automatic string txnText(input logic [16:0] t);
		return t[16] ? $sformatf("write %02h <- %02h", t[15:8], t[7:0]) :
			$sformatf("read %02h", t[15:8]);
	endfunction

	// inputs settle 1 ns after the edge, so the falling edge sees a whole cycle.
	always @(negedge clk) begin
		logic [16:0] act;
		if (!rstN) begin
			if (inReset && (memReq.valid || halted))
				reportError("valid or halted still high after a reset edge");
			inReset = 1'b1;
			prevValid = 1'b0;
			prevAcc = 1'b0;
		end else begin
			inReset = 1'b0;
			if (prevValid && !prevAcc && !memReq.valid)
				reportError("request was dropped before its acknowledge");
			else if (prevValid && !prevAcc && memReq != prevReq)
				reportError("request fields changed while waiting for the acknowledge");
			if (halted && memReq.valid)
				reportError("memory request issued after HALT");
			if (memReq.valid && memAck) begin
				act = {memReq.write, memReq.addr, memReq.write ? memReq.wdata : 8'h00};
				if (idx >= expTxn.size()) begin
					reportError("more memory transactions than the model expects");
				end else if (act != expTxn[idx]) begin
					$display("CHECK FAILED %s: transaction %0d expected %s, actual %s",
						testName, idx, txnText(expTxn[idx]), txnText(act));
					errors++;
				end
				idx++;
			end
			prevValid = memReq.valid;
			prevAcc = memReq.valid && memAck;
			prevReq = memReq;
		end
	end

	task automatic closeTest(output int errCount);
		if (idx < expTxn.size())
			reportError($sformatf("only %0d of %0d transactions seen", idx, expTxn.size()));
		if (!halted)
			reportError("halted is low at the end of the program");
		$display("test %-16s %3d transactions  %s", testName, idx,
			(errors == 0) ? "ok" : $sformatf("%0d errors", errors));
		errCount = errors;
	endtask

endmodule

// File: include/cpuTbModel.svh
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

int unsigned      lcgState = 37;
cpuIsaPkg::word_t progImage [256];
logic [16:0]      expTxn [$];	// {write, addr, wdata}.
cpuIsaPkg::word_t genOp [48];
cpuIsaPkg::word_t genAt [48];

function automatic int unsigned randBelow(input int unsigned n);
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return (lcgState >> 16) % n;
endfunction

function automatic bit hasOperand(input cpuIsaPkg::word_t op);
	return op == cpuIsaPkg::LDADDR || op == cpuIsaPkg::JMP || op == cpuIsaPkg::JMPZ;
endfunction

// ******************************
// ISA reference model
// ******************************

function automatic bit runModel();
	cpuIsaPkg::word_t m [256];
	cpuIsaPkg::word_t pc, ac, addr, stp, op;
	m = progImage;
	pc = '0;
	ac = '0;
	addr = '0;
	stp = '0;
	expTxn.delete();
	while (expTxn.size() < STEP_LIMIT) begin
		expTxn.push_back({1'b0, pc, 8'h00});	// fetch.
		op = m[pc];
		pc = pc + 8'd1;
		case (cpuIsaPkg::opcode_e'(op))
			cpuIsaPkg::HALT:   return 1'b1;
			cpuIsaPkg::LDAC: begin
				expTxn.push_back({1'b0, addr, 8'h00});
				ac = m[addr];
			end
			cpuIsaPkg::ADD:    ac = ac + addr;
			cpuIsaPkg::INCAC:  ac = ac + 8'd1;
			cpuIsaPkg::RSTAC:  ac = '0;
			cpuIsaPkg::MADDR:  addr = ac;
			cpuIsaPkg::MSTP:   stp = ac;
			cpuIsaPkg::INCSTP: stp = stp + 8'd1;
			cpuIsaPkg::STSP: begin
				expTxn.push_back({1'b1, stp, ac});
				m[stp] = ac;
			end
			cpuIsaPkg::LDADDR, cpuIsaPkg::JMP, cpuIsaPkg::JMPZ: begin
				if (op == cpuIsaPkg::JMPZ && ac != '0) begin
					pc = pc + 8'd1;	// not taken.
				end else begin
					expTxn.push_back({1'b0, pc, 8'h00});
					if (op == cpuIsaPkg::LDADDR) begin
						addr = m[pc];
						pc = pc + 8'd1;
					end else begin
						pc = m[pc];
					end
				end
			end
			default: ;
		endcase
	end
	return 1'b0;	// too long, caller draws again.
endfunction

// random program in low memory, random data above 0x80.
function automatic void buildProgram();
	int n;
	int at;
	int span;
	do begin
		n = 20 + int'(randBelow(21));
		at = 0;
		for (int i = 0; i < n; i++) begin
			genOp[i] = (i == n - 1) ? 8'h00 : 8'(randBelow(11) + 1);
			genAt[i] = 8'(at);
			at += hasOperand(genOp[i]) ? 2 : 1;
		end
		for (int a = 0; a < 256; a++) begin
			progImage[a] = (a < 128) ? 8'h00 : 8'(randBelow(256));
		end
		for (int i = 0; i < n; i++) begin
			progImage[genAt[i]] = genOp[i];
			span = (n - 1 - i < 4) ? n - 1 - i : 4;
			if (genOp[i] == cpuIsaPkg::LDADDR) begin
				progImage[genAt[i] + 8'd1] = 8'h80 | 8'(randBelow(128));
			end else if (hasOperand(genOp[i])) begin	// forward jump only.
				progImage[genAt[i] + 8'd1] = genAt[i + 1 + int'(randBelow(span))];
			end
		end
	end while (!runModel());
endfunction

`endif

// File: test/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

	localparam int NUM_TESTS  = 12;
	localparam int STEP_LIMIT = 150;	// transactions per program.
	localparam int RESET_TEST = 4;

	logic               clk;
	logic               rstN;
	logic               resetHold;
	cpuBusPkg::memReq_t memReq;
	logic               memAck;
	cpuIsaPkg::word_t   memRdata;
	logic               halted;
	cpuIsaPkg::word_t   mem [256];
	int                 waitLeft;
	logic               pendWrite;
	cpuIsaPkg::word_t   pendAddr;
	cpuIsaPkg::word_t   pendData;

	`include "cpuTbModel.svh"

	cpuTop dut (.clk(clk), .rstN(rstN), .memReq(memReq), .memAck(memAck),
		.memRdata(memRdata), .halted(halted));

	cpuChecker chk (.clk(clk), .rstN(rstN), .memReq(memReq), .memAck(memAck),
		.halted(halted));

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ******************************
	// memory with random ack delay
	// ******************************

	always @(posedge clk) begin
		#1;
		rstN = !resetHold;
		if (!rstN) begin
			memAck = 1'b0;
			waitLeft = -1;
		end else if (memAck) begin	// accepted at the edge just passed.
			if (pendWrite)
				mem[pendAddr] = pendData;
			memAck = 1'b0;
			waitLeft = -1;
		end else if (memReq.valid) begin
			if (waitLeft < 0)
				waitLeft = int'(randBelow(4));
			if (waitLeft == 0) begin
				memAck = 1'b1;
				memRdata = mem[memReq.addr];
				pendWrite = memReq.write;
				pendAddr = memReq.addr;
				pendData = memReq.wdata;
			end else begin
				waitLeft--;
			end
		end
	end

	task automatic startProgram(input string name, input bit fresh);
		if (fresh)
			chk.arm(name);
		@(negedge clk) resetHold = 1'b1;
		repeat (4) @(posedge clk);
		mem = progImage;
		chk.rewind();
		foreach (expTxn[i])
			chk.addExpected(expTxn[i]);
		@(negedge clk) resetHold = 1'b0;
	endtask

	task automatic runTest(input int t, input bit midReset, output int errs);
		string name;
		name = midReset ? $sformatf("reset_rerun_%0d", t) : $sformatf("random_%0d", t);
		buildProgram();
		startProgram(name, 1'b1);
		if (midReset) begin	// cut in halfway, then run it again from address 0.
			while (chk.idx < expTxn.size() / 2)
				@(posedge clk);
			startProgram(name, 1'b0);
		end
		while (!halted)
			@(posedge clk);
		repeat (20) @(posedge clk);
		chk.closeTest(errs);
	endtask

	initial begin
		int errs;
		int passCount;
		int failCount;
		resetHold = 1'b1;
		rstN = 1'b0;
		memAck = 1'b0;
		memRdata = '0;
		waitLeft = -1;
		pendWrite = 1'b0;
		pendAddr = '0;
		pendData = '0;
		passCount = 0;
		failCount = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			runTest(t, t == RESET_TEST, errs);
			if (errs == 0)
				passCount++;
			else
				failCount++;
		end
		$display("tests %0d, passed %0d, failed %0d", NUM_TESTS, passCount, failCount);
		if (failCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		repeat ((NUM_TESTS + 1) * STEP_LIMIT * 8) @(posedge clk);
		$display("watchdog expired, the CPU stopped making progress");
		$display("*** FAILED ***");
		$finish;
	end

endmodule
